// File: design/fill_settings.svh
`ifndef FILL_SETTINGS_SVH
`define FILL_SETTINGS_SVH

// Screen geometry for the fill engine
// Frame buffer is 160 columns by 120 rows

// Number of columns across the screen
`define FILL_WIDTH 160

// Number of rows down the screen
`define FILL_HEIGHT 120

// Last column index, where x wraps
`define FILL_LAST_X (`FILL_WIDTH - 1)

// Last row index, where y wraps and x advances
`define FILL_LAST_Y (`FILL_HEIGHT - 1)

// A full pass plots FILL_WIDTH * FILL_HEIGHT pixels
// The scan walks columns, so y is the fast counter
// The colour comes from the low x bits, giving 8-column bands

`endif

// File: design/fill_pkg.sv
`default_nettype none

// Shared types for the screen-fill engine
package fill_pkg;

    // Column coordinate, 0 to 159
    // Eight bits hold the full width
    typedef logic [7:0] pixel_x_t;

    // Row coordinate, 0 to 119
    // Seven bits hold the full height
    typedef logic [6:0] pixel_y_t;

    // Three-bit frame buffer colour
    // Eight colours, one per band
    typedef logic [2:0] colour_t;

    // Fill sequencer states
    typedef enum logic [1:0] {
        // Waiting for start, counters held clear
        IDLE = 2'd0,
        // One pixel per cycle, column by column
        DRAW = 2'd1,
        // Pass finished, done held until start drops
        DONE = 2'd2
    } fill_state_t;

endpackage

`default_nettype wire

// File: design/fill_scan_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "fill_settings.svh"

// Scan stage
// Walks the screen column by column, y fastest
module fill_scan_counter (
    input  logic               clk,
    input  logic               x_clear,
    input  logic               y_clear,
    input  logic               y_step,
    output fill_pkg::pixel_x_t x_count,
    output fill_pkg::pixel_y_t y_count,
    output logic               last_pixel
);

    import fill_pkg::*;

    // Next count values
    pixel_x_t x_next;
    pixel_y_t y_next;

    // Counter at its last value
    logic     x_at_last;
    logic     y_at_last;

    // End of column and end of row detection
    assign y_at_last = (y_count == pixel_y_t'(`FILL_LAST_Y));
    assign x_at_last = (x_count == pixel_x_t'(`FILL_LAST_X));

    // Final coordinate of the pass
    // Lets the controller stop without comparing coordinates
    assign last_pixel = x_at_last && y_at_last;

    // Next count logic
    always_comb begin
        // Hold by default
        x_next = x_count;
        y_next = y_count;

        if (y_step) begin
            if (y_at_last) begin
                // Column finished, back to the top row
                y_next = '0;
                // x moves on the same step that wraps y
                if (x_at_last) begin
                    x_next = '0;
                end else begin
                    x_next = x_count + 1'b1;
                end
            end else begin
                y_next = y_count + 1'b1;
            end
        end

        // Clears win over the step
        if (y_clear) begin
            y_next = '0;
        end
        if (x_clear) begin
            x_next = '0;
        end
    end

    // Count registers
    // Cleared by the controller while idle
    always_ff @(posedge clk) begin
        x_count <= x_next;
        y_count <= y_next;
    end

endmodule

`default_nettype wire

// File: design/fill_control_fsm.sv
`timescale 1ns/1ns
`default_nettype none

// Control stage
// Sequences idle, draw and done for one fill pass
module fill_control_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last_pixel,
    output logic x_clear,
    output logic y_clear,
    output logic y_step,
    output logic pixel_valid,
    output logic fill_done
);

    import fill_pkg::*;

    // Current and next state
    fill_state_t state;
    fill_state_t state_next;

    // State register, synchronous active-low reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Next state logic
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Start level launches a pass
                if (start) begin
                    state_next = DRAW;
                end
            end
            DRAW: begin
                // Start is ignored here, the pass always completes
                if (last_pixel) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                // Wait for start to drop before rearming
                if (!start) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Output decode
    always_comb begin
        // Defaults, each state raises only its own strobes
        x_clear     = 1'b0;
        y_clear     = 1'b0;
        y_step      = 1'b0;
        pixel_valid = 1'b0;
        fill_done   = 1'b0;

        case (state)
            IDLE: begin
                // Hold both counters at the origin
                x_clear = 1'b1;
                y_clear = 1'b1;
            end
            DRAW: begin
                // One pixel per cycle
                // Step still fires on the last pixel so the counters wrap to zero
                y_step      = 1'b1;
                pixel_valid = 1'b1;
            end
            DONE: begin
                fill_done = 1'b1;
            end
            default: begin
                // Unused encoding, drives nothing
                fill_done = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/fill_pixel_stage.sv
`timescale 1ns/1ns
`default_nettype none

// Pixel output stage
// One register between the scan counters and the frame buffer port
module fill_pixel_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pixel_valid,
    input  logic               fill_done,
    input  fill_pkg::pixel_x_t x_count,
    input  fill_pkg::pixel_y_t y_count,
    output logic               vga_plot,
    output fill_pkg::pixel_x_t vga_x,
    output fill_pkg::pixel_y_t vga_y,
    output fill_pkg::colour_t  vga_colour,
    output logic               done
);

    import fill_pkg::*;

    // Colour band of the current column
    colour_t colour_band;

    // Low three x bits pick one of eight colours
    // Bands repeat every eight columns
    assign colour_band = x_count[2:0];

    // Plot strobe and done
    // done lines up with the edge where the last plot drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_plot <= 1'b0;
            done     <= 1'b0;
        end else begin
            vga_plot <= pixel_valid;
            done     <= fill_done;
        end
    end

    // Pixel coordinates and colour
    // Outputs are zero after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_x      <= '0;
            vga_y      <= '0;
            vga_colour <= '0;
        end else begin
            // Follows the counters every cycle
            // Only meaningful while vga_plot is high
            vga_x      <= x_count;
            vga_y      <= y_count;
            vga_colour <= colour_band;
        end
    end

endmodule

`default_nettype wire

// File: design/fillscreen.sv
`timescale 1ns/1ns
`default_nettype none

// Screen-fill engine top level
// Scan counters feed the output register, the FSM steers both
module fillscreen (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               done,
    output fill_pkg::pixel_x_t vga_x,
    output fill_pkg::pixel_y_t vga_y,
    output fill_pkg::colour_t  vga_colour,
    output logic               vga_plot
);

    import fill_pkg::*;

    // Counter controls from the FSM
    logic     x_clear;
    logic     y_clear;
    logic     y_step;

    // Status back from the scan stage
    logic     last_pixel;

    // Current scan position
    pixel_x_t x_count;
    pixel_y_t y_count;

    // Pixel qualifiers into the output stage
    logic     pixel_valid;
    logic     fill_done;

    // Control stage
    fill_control_fsm u_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .last_pixel  (last_pixel),
        .x_clear     (x_clear),
        .y_clear     (y_clear),
        .y_step      (y_step),
        .pixel_valid (pixel_valid),
        .fill_done   (fill_done)
    );

    // Scan stage, cleared while idle
    fill_scan_counter u_scan (
        .clk        (clk),
        .x_clear    (x_clear),
        .y_clear    (y_clear),
        .y_step     (y_step),
        .x_count    (x_count),
        .y_count    (y_count),
        .last_pixel (last_pixel)
    );

    // Output stage
    // Adds one cycle from the scan position to the plot
    fill_pixel_stage u_pixel (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .fill_done   (fill_done),
        .x_count     (x_count),
        .y_count     (y_count),
        .vga_plot    (vga_plot),
        .vga_x       (vga_x),
        .vga_y       (vga_y),
        .vga_colour  (vga_colour),
        .done        (done)
    );

endmodule

`default_nettype wire

// File: sim/fillscreen_checker.sv
`timescale 1ns/1ns
`default_nettype none

// Protocol assertions for the fill engine top level
module fillscreen_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               start,
    input logic               done,
    input fill_pkg::pixel_x_t vga_x,
    input fill_pkg::colour_t  vga_colour,
    input logic               vga_plot
);

    import fill_pkg::*;

    // Number of failed assertions, read by the testbench
    int fail_count = 0;

    // A pixel strobe never overlaps the done level
    plot_not_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(vga_plot && done))
        else begin
            $error("vga_plot and done high together");
            fail_count++;
        end

    // done holds while start stays high
    done_held_by_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start && $past(start) && done) |=> done)
        else begin
            $error("done dropped while start was high");
            fail_count++;
        end

    // Colour band follows the low x bits on every plotted pixel
    colour_matches_x: assert property (@(posedge clk) disable iff (!rst_n)
        vga_plot |-> (vga_colour == vga_x[2:0]))
        else begin
            $error("vga_colour does not match vga_x band");
            fail_count++;
        end

endmodule

// Attach the checker to every fillscreen instance
bind fillscreen fillscreen_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .done       (done),
    .vga_x      (vga_x),
    .vga_colour (vga_colour),
    .vga_plot   (vga_plot)
);

`default_nettype wire

// File: sim/fillscreen_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fill_settings.svh"

// Testbench for the screen-fill engine
module fillscreen_tb;

    import fill_pkg::*;

    // Passes to run, each with its own random gap and hold
    localparam int NUM_PASSES = 4;
    localparam int PIXELS = `FILL_WIDTH * `FILL_HEIGHT;
    // Negedge samples from the driving edge to the first plot
    localparam int PLOT_LATENCY = 3;
    // Negedge samples from dropping start to done low
    localparam int DONE_CLEAR_LATENCY = 3;
    localparam int WAIT_LIMIT = 20;
    localparam logic [31:0] LFSR_SEED = 32'hcbf1_e9d5;

    logic     clk;
    logic     rst_n;
    logic     start;
    logic     done;
    pixel_x_t vga_x;
    pixel_y_t vga_y;
    colour_t  vga_colour;
    logic     vga_plot;

    logic [31:0] lfsr;
    int          check_errors;
    int          timeout_errors;

    fillscreen u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // Gather n random bits into an integer
    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_bit());
        end
        return value;
    endfunction

    task automatic check_coord(input pixel_x_t got_x, input pixel_y_t got_y,
                               input pixel_x_t exp_x, input pixel_y_t exp_y);
        if (got_x !== exp_x || got_y !== exp_y) begin
            $display("CHECK FAILED at %0t ns: pixel (%0d,%0d), expected (%0d,%0d)",
                     $time, got_x, got_y, exp_x, exp_y);
            check_errors++;
        end
    endtask

    task automatic check_colour(input colour_t got, input colour_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: colour %0d, expected %0d", $time, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            check_errors++;
        end
    endtask

    // Count negedges until the first plot strobe
    task automatic wait_for_plot(output int cycles, output bit ok);
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (vga_plot === 1'b1) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            $display("Timeout: vga_plot never rose after start was raised");
            timeout_errors++;
        end
    endtask

    // Count negedges until done clears
    task automatic wait_for_done_low(output int cycles, output bit ok);
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (done === 1'b0) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            $display("Timeout: done stayed high after start was dropped");
            timeout_errors++;
        end
    endtask

    // One full pass: idle gap, start, 19200 pixels, done hold, release
    task automatic run_pass(output bit ok);
        int       gap;
        int       hold;
        int       cycles;
        pixel_x_t exp_x;
        pixel_y_t exp_y;
        gap = take_bits(4) + 1;
        hold = take_bits(4);
        ok = 1'b1;
        repeat (gap) begin
            @(negedge clk);
            check_flag(vga_plot, 1'b0, "vga_plot while idle");
            check_flag(done, 1'b0, "done while idle");
        end
        @(posedge clk);
        start <= 1'b1;
        wait_for_plot(cycles, ok);
        if (!ok) begin
            return;
        end
        check_count(cycles, PLOT_LATENCY, "cycles from start to first plot");
        // Model walks column-major from the origin
        exp_x = '0;
        exp_y = '0;
        for (int i = 0; i < PIXELS; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            check_flag(vga_plot, 1'b1, "vga_plot during pass");
            check_flag(done, 1'b0, "done during pass");
            check_coord(vga_x, vga_y, exp_x, exp_y);
            check_colour(vga_colour, colour_t'(exp_x % 8'd8));
            if (exp_y == pixel_y_t'(`FILL_LAST_Y)) begin
                exp_y = '0;
                exp_x = exp_x + 8'd1;
            end else begin
                exp_y = exp_y + 7'd1;
            end
        end
        // done takes over on the edge where plotting stops
        @(negedge clk);
        check_flag(vga_plot, 1'b0, "vga_plot after last pixel");
        check_flag(done, 1'b1, "done after last pixel");
        repeat (hold) begin
            @(negedge clk);
            check_flag(done, 1'b1, "done while start held");
            check_flag(vga_plot, 1'b0, "vga_plot while done");
        end
        @(posedge clk);
        start <= 1'b0;
        wait_for_done_low(cycles, ok);
        if (!ok) begin
            return;
        end
        check_count(cycles, DONE_CLEAR_LATENCY, "cycles from start low to done low");
    endtask

    // Closing summary and verdict
    task automatic finish_run();
        int assert_errors;
        assert_errors = u_dut.u_checker.fail_count;
        $display("Errors: %0d value, %0d timeout, %0d assertion",
                 check_errors, timeout_errors, assert_errors);
        if (check_errors + timeout_errors + assert_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        int pass_idx;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        lfsr = LFSR_SEED;
        check_errors = 0;
        timeout_errors = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet outputs before any start
        @(negedge clk);
        check_flag(vga_plot, 1'b0, "vga_plot after reset");
        check_flag(done, 1'b0, "done after reset");
        check_coord(vga_x, vga_y, '0, '0);
        check_colour(vga_colour, '0);
        ok = 1'b1;
        for (pass_idx = 0; pass_idx < NUM_PASSES && ok; pass_idx++) begin
            run_pass(ok);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/fill_pkg.sv
design/fill_scan_counter.sv
design/fill_control_fsm.sv
design/fill_pixel_stage.sv
design/fillscreen.sv
sim/fillscreen_checker.sv
sim/fillscreen_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the fill engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f sources.f \
    --top-module fillscreen_tb -o fillscreen_sim > build.log 2>&1 \
    && ./obj_dir/fillscreen_sim > "$LOG" 2>&1 \
    || echo "Build or simulation returned an error"

# Verdict comes from the simulation log
grep -q '^\*\*\* PASSED \*\*\*$' "$LOG" 2>/dev/null \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see $LOG and build.log"; exit 1; }
